/* conv_router.f */
src/conv_pkg.sv
src/conv_cfg_if.sv
src/conv_window_if.sv
src/conv_row_sequencer.sv
src/conv_line_buf_map.sv
src/conv_router.sv
sim/conv_router_chk.sv
sim/conv_router_monitor.sv
sim/conv_router_tb.sv

/* sim/conv_router_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module conv_router_tb;
    import conv_pkg::*;

    localparam int route_timeout = 100;
    localparam int end_timeout   = 10;
    localparam int random_tests  = 20;

    logic                 clk, reset, en, shift_add_end;
    logic [dim_w-1:0]     ix, iy, ox, oy, nif;
    logic [krn_w-1:0]     k, s, p;
    logic [log_w-1:0]     ix_in_2pow, nif_in_2pow;
    logic                 route_valid, busy, conv_end;
    logic [dim_w-1:0]     if_idx, row1_idx, row2_idx, row3_idx;
    logic [line_bufs-1:0] row_mask;
    logic [slot_w-1:0]    row1_buf_idx, row2_buf_idx, row3_buf_idx;
    logic [dim_w-1:0]     row1_buf_adr, row2_buf_adr, row3_buf_adr;
    logic [8*16-1:0]      test_name;
    int                   errors, ends;
    int                   seed, tests_run, tests_bad;
    bit                   timed_out;

    conv_router dut_i (.*);
    conv_router_monitor mon_i (.*);

    always #10 clk = ~clk;

    function automatic int draw(input int span);
        return {$random(seed)} % span;
    endfunction

    task automatic load_config(input int ix_log, iy_v, oy_v, nif_log, k_v, s_v, p_v);
        ix          = dim_w'(1 << ix_log);
        ix_in_2pow  = log_w'(ix_log);
        nif         = dim_w'(1 << nif_log);
        nif_in_2pow = log_w'(nif_log);
        iy          = dim_w'(iy_v);
        oy          = dim_w'(oy_v);
        ox          = dim_w'(oy_v);
        k           = krn_w'(k_v);
        s           = krn_w'(s_v);
        p           = krn_w'(p_v);
    endtask

    task automatic wait_route(output bit ok);
        int n;
        n = 0;
        while (!route_valid && n < route_timeout) begin
            @(negedge clk);
            n++;
        end
        ok = route_valid;
        if (!ok) begin
            $display("Timeout in %0s: no window appeared on route_valid", test_name);
        end
    endtask

    ////////////////////////////////////////
    // One layer, start pulse to conv_end
    ////////////////////////////////////////

    task automatic run_layer(input logic [8*16-1:0] name, input bit stress);
        int  err0;
        int  end0;
        int  total;
        int  n;
        bit  ok;
        if (!timed_out) begin
            test_name = name;
            err0 = errors;
            end0 = ends;
            total = oy * nif;
            ok = 1;
            // Stray consume pulse rides along with the start
            en = 1;
            shift_add_end = stress;
            @(negedge clk);
            en = 0;
            shift_add_end = 0;
            for (int w = 0; w < total && ok; w++) begin
                wait_route(ok);
                if (ok) begin
                    if (stress) begin
                        // Hold off the consume, start pulses must be ignored here
                        repeat (draw(4)) begin
                            en = (draw(2) == 1);
                            @(negedge clk);
                        end
                        en = 0;
                    end
                    shift_add_end = 1;
                    @(negedge clk);
                    if (stress && draw(2) == 1) begin
                        @(negedge clk);
                    end
                    shift_add_end = 0;
                end
            end
            n = 0;
            while (ok && ends == end0 && n < end_timeout) begin
                @(negedge clk);
                n++;
            end
            if (ok && ends == end0) begin
                $display("Timeout in %0s: conv_end never came", name);
                ok = 0;
            end
            timed_out = !ok;
            tests_run++;
            if (!ok || errors != err0) begin
                tests_bad++;
            end
            $display("Test %0s: %0d windows, %0d errors", name, total, errors - err0);
        end
    endtask

    initial begin
        logic [8*16-1:0] name;
        seed = 49;
        clk = 0;
        reset = 1;
        en = 0;
        shift_add_end = 0;
        test_name = "reset";
        tests_run = 0;
        tests_bad = 0;
        timed_out = 0;
        load_config(7, 128, 32, 0, 3, 1, 1);
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 0;

        run_layer("reference", 0);
        load_config(7, 16, 8, 2, 3, 1, 1);
        run_layer("channels", 0);
        load_config(4, 9, 7, 1, 3, 2, 2);
        run_layer("stride_pad", 0);
        load_config(5, 6, 6, 0, 1, 1, 0);
        run_layer("kernel_1", 0);
        load_config(5, 6, 7, 1, 2, 1, 2);
        run_layer("kernel_2", 0);
        load_config(6, 12, 10, 1, 3, 1, 1);
        run_layer("back_pressure", 1);

        for (int i = 0; i < random_tests; i++) begin
            load_config(2 + draw(6), 3 + draw(18), 1 + draw(8), draw(3),
                        1 + draw(3), 1 + draw(4), draw(3));
            $sformat(name, "random_%0d", i);
            run_layer(name, 1);
        end

        $display("Summary: %0d tests run, %0d with errors, %0d errors, %0d assertion failures",
                 tests_run, tests_bad, errors, dut_i.chk_i.fail_count);
        if (tests_bad == 0 && errors == 0 && dut_i.chk_i.fail_count == 0 && !timed_out) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim/conv_router_monitor.sv */
`timescale 1ns/100ps
`default_nettype none

module conv_router_monitor (
    input  logic                           clk, reset, en, shift_add_end,
    input  logic [conv_pkg::dim_w-1:0]     iy, oy, nif,
    input  logic [conv_pkg::krn_w-1:0]     k, s, p,
    input  logic [conv_pkg::log_w-1:0]     ix_in_2pow,
    input  logic                           route_valid, busy, conv_end,
    input  logic [conv_pkg::dim_w-1:0]     if_idx, row1_idx, row2_idx, row3_idx,
    input  logic [conv_pkg::line_bufs-1:0] row_mask,
    input  logic [conv_pkg::slot_w-1:0]    row1_buf_idx, row2_buf_idx, row3_buf_idx,
    input  logic [conv_pkg::dim_w-1:0]     row1_buf_adr, row2_buf_adr, row3_buf_adr,
    input  logic [8*16-1:0]                test_name,
    output int                             errors,
    output int                             ends
);
    import conv_pkg::*;

    int  cfg_iy, cfg_oy, cfg_nif, cfg_k, cfg_s, cfg_p, cfg_log;
    int  oy_i, ch, run_windows, cyc, start_cyc, cons_cyc;
    bit  active, first, rv_prev;
    logic [3*dim_w-1:0]  act_rows, act_adrs;
    logic [3*slot_w-1:0] act_slots;

    assign act_rows  = {row3_idx, row2_idx, row1_idx};
    assign act_adrs  = {row3_buf_adr, row2_buf_adr, row1_buf_adr};
    assign act_slots = {row3_buf_idx, row2_buf_idx, row1_buf_idx};

    // Expected window for output row r and channel c
    function automatic void ref_window(input int r, input int c, output logic [2:0] mask,
                                       output logic [3*dim_w-1:0] rows,
                                       output logic [3*slot_w-1:0] slots,
                                       output logic [dim_w-1:0] adr);
        int row;
        for (int j = 0; j < 3; j++) begin
            row = r * cfg_s - cfg_p + j;
            mask[j] = (j < cfg_k) && (row >= 0) && (row < cfg_iy);
            rows[j*dim_w +: dim_w] = row[dim_w-1:0];
            slots[j*slot_w +: slot_w] = slot_w'(((row % 3) + 3) % 3);
        end
        adr = dim_w'(c << cfg_log);
    endfunction

    task automatic check_field(input string what, input logic [dim_w-1:0] exp_v, act_v);
        if (exp_v !== act_v) begin
            $display("Mismatch %0s %0s: expected 0x%h, actual 0x%h",
                     test_name, what, exp_v, act_v);
            errors++;
        end
    endtask

    initial begin
        errors = 0;
        ends = 0;
        cyc = 0;
        active = 0;
    end

    always @(posedge clk) begin
        logic [2:0]          mask;
        logic [3*dim_w-1:0]  rows;
        logic [3*slot_w-1:0] slots;
        logic [dim_w-1:0]    adr;
        cyc++;
        if (reset) begin
            active = 0;
        end else begin
            if (conv_end) begin
                ends++;
                check_field("window count", dim_w'(cfg_oy * cfg_nif), dim_w'(run_windows));
                check_field("conv_end delay", dim_w'(1), dim_w'(cyc - cons_cyc));
                if (busy || !active) begin
                    $display("Error in %0s: conv_end with busy high or no layer", test_name);
                    errors++;
                end
                active = 0;
            end
            // Start to first route is 3 cycles, consume to next route 2
            if (route_valid && !rv_prev && active) begin
                check_field("route latency", first ? dim_w'(3) : dim_w'(2),
                            dim_w'(cyc - (first ? start_cyc : cons_cyc)));
                first = 0;
            end
            if (route_valid && shift_add_end && active) begin
                if (oy_i >= cfg_oy) begin
                    $display("Error in %0s: window after the last output row", test_name);
                    errors++;
                end else begin
                    ref_window(oy_i, ch, mask, rows, slots, adr);
                    check_field("if_idx", dim_w'(ch), if_idx);
                    check_field("row_mask", dim_w'(mask), dim_w'(row_mask));
                    for (int j = 0; j < 3; j++) begin
                        if (mask[j]) begin
                            check_field($sformatf("row%0d_idx", j + 1),
                                        rows[j*dim_w +: dim_w], act_rows[j*dim_w +: dim_w]);
                            check_field($sformatf("row%0d_buf_idx", j + 1),
                                        dim_w'(slots[j*slot_w +: slot_w]),
                                        dim_w'(act_slots[j*slot_w +: slot_w]));
                            check_field($sformatf("row%0d_buf_adr", j + 1),
                                        adr, act_adrs[j*dim_w +: dim_w]);
                        end
                    end
                end
                run_windows++;
                cons_cyc = cyc;
                ch++;
                if (ch >= cfg_nif) begin
                    ch = 0;
                    oy_i++;
                end
            end
            // New layer, only taken while idle
            if (en && !busy) begin
                cfg_iy = iy;
                cfg_oy = oy;
                cfg_nif = nif;
                cfg_k = k;
                cfg_s = s;
                cfg_p = p;
                cfg_log = ix_in_2pow;
                oy_i = 0;
                ch = 0;
                run_windows = 0;
                start_cyc = cyc;
                active = 1;
                first = 1;
            end
        end
        rv_prev = route_valid;
    end

endmodule

`default_nettype wire

/* sim/conv_router_chk.sv */
`timescale 1ns/100ps
`default_nettype none

module conv_router_chk (
    input logic                           clk, reset, shift_add_end,
    input logic                           route_valid, busy, conv_end,
    input logic [conv_pkg::dim_w-1:0]     if_idx, row1_idx, row2_idx, row3_idx,
    input logic [conv_pkg::line_bufs-1:0] row_mask,
    input logic [conv_pkg::slot_w-1:0]    row1_buf_idx, row2_buf_idx, row3_buf_idx,
    input logic [conv_pkg::dim_w-1:0]     row1_buf_adr, row2_buf_adr, row3_buf_adr
);

    int fail_count = 0;

    ////////////////////////////////////////
    // End pulse
    ////////////////////////////////////////

    end_single: assert property (@(posedge clk) disable iff (reset) conv_end |=> !conv_end)
        else begin
            $error("conv_end stayed high for more than one cycle");
            fail_count++;
        end

    end_alone: assert property (@(posedge clk) disable iff (reset) !(conv_end && route_valid))
        else begin
            $error("conv_end and route_valid high together");
            fail_count++;
        end

    // A waiting window holds every field
    hold_window: assert property (@(posedge clk) disable iff (reset)
        route_valid && !shift_add_end |=> route_valid && $stable({if_idx, row1_idx,
            row2_idx, row3_idx, row_mask, row1_buf_idx, row2_buf_idx, row3_buf_idx,
            row1_buf_adr, row2_buf_adr, row3_buf_adr}))
        else begin
            $error("window changed or dropped before shift_add_end");
            fail_count++;
        end

    idle_after_reset: assert property (@(posedge clk) reset |=> !busy && !route_valid && !conv_end)
        else begin
            $error("busy, route_valid or conv_end high after reset");
            fail_count++;
        end

endmodule

bind conv_router conv_router_chk chk_i (.*);

`default_nettype wire

/* src/conv_router.sv */
`timescale 1ns/100ps
`default_nettype none

module conv_router (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           en,
    input  logic [conv_pkg::dim_w-1:0]     ix,
    input  logic [conv_pkg::dim_w-1:0]     iy,
    input  logic [conv_pkg::dim_w-1:0]     ox,
    input  logic [conv_pkg::dim_w-1:0]     oy,
    input  logic [conv_pkg::dim_w-1:0]     nif,
    input  logic [conv_pkg::krn_w-1:0]     k,
    input  logic [conv_pkg::krn_w-1:0]     s,
    input  logic [conv_pkg::krn_w-1:0]     p,
    input  logic [conv_pkg::log_w-1:0]     ix_in_2pow,
    input  logic [conv_pkg::log_w-1:0]     nif_in_2pow,
    input  logic                           shift_add_end,
    output logic                           route_valid,
    output logic [conv_pkg::dim_w-1:0]     if_idx,
    output logic [conv_pkg::dim_w-1:0]     row1_idx,
    output logic [conv_pkg::dim_w-1:0]     row2_idx,
    output logic [conv_pkg::dim_w-1:0]     row3_idx,
    output logic [conv_pkg::line_bufs-1:0] row_mask,
    output logic [conv_pkg::slot_w-1:0]    row1_buf_idx,
    output logic [conv_pkg::slot_w-1:0]    row2_buf_idx,
    output logic [conv_pkg::slot_w-1:0]    row3_buf_idx,
    output logic [conv_pkg::dim_w-1:0]     row1_buf_adr,
    output logic [conv_pkg::dim_w-1:0]     row2_buf_adr,
    output logic [conv_pkg::dim_w-1:0]     row3_buf_adr,
    output logic                           busy,
    output logic                           conv_end
);

    logic consume;

    conv_cfg_if    cfg_bus ();
    conv_window_if win_bus ();

    ////////////////////////////////////////
    // Row and channel stepping
    ////////////////////////////////////////

    conv_row_sequencer seq_i (
        .clk         (clk),
        .reset       (reset),
        .en          (en),
        .ix          (ix),
        .iy          (iy),
        .ox          (ox),
        .oy          (oy),
        .nif         (nif),
        .k           (k),
        .s           (s),
        .p           (p),
        .ix_in_2pow  (ix_in_2pow),
        .nif_in_2pow (nif_in_2pow),
        .consume     (consume),
        .cfg         (cfg_bus.owner),
        .win         (win_bus.issuer),
        .busy        (busy),
        .conv_end    (conv_end)
    );

    ////////////////////////////////////////
    // Window to line buffer mapping
    ////////////////////////////////////////

    conv_line_buf_map map_i (
        .clk           (clk),
        .reset         (reset),
        .cfg           (cfg_bus.user),
        .win           (win_bus.mapper),
        .shift_add_end (shift_add_end),
        .consume       (consume),
        .route_valid   (route_valid),
        .if_idx        (if_idx),
        .row1_idx      (row1_idx),
        .row2_idx      (row2_idx),
        .row3_idx      (row3_idx),
        .row_mask      (row_mask),
        .row1_buf_idx  (row1_buf_idx),
        .row2_buf_idx  (row2_buf_idx),
        .row3_buf_idx  (row3_buf_idx),
        .row1_buf_adr  (row1_buf_adr),
        .row2_buf_adr  (row2_buf_adr),
        .row3_buf_adr  (row3_buf_adr)
    );

endmodule

`default_nettype wire

/* src/conv_line_buf_map.sv */
`timescale 1ns/100ps
`default_nettype none

module conv_line_buf_map (
    input  logic                           clk,
    input  logic                           reset,
    conv_cfg_if.user                       cfg,
    conv_window_if.mapper                  win,
    input  logic                           shift_add_end,
    output logic                           consume,
    output logic                           route_valid,
    output logic [conv_pkg::dim_w-1:0]     if_idx,
    output logic [conv_pkg::dim_w-1:0]     row1_idx,
    output logic [conv_pkg::dim_w-1:0]     row2_idx,
    output logic [conv_pkg::dim_w-1:0]     row3_idx,
    output logic [conv_pkg::line_bufs-1:0] row_mask,
    output logic [conv_pkg::slot_w-1:0]    row1_buf_idx,
    output logic [conv_pkg::slot_w-1:0]    row2_buf_idx,
    output logic [conv_pkg::slot_w-1:0]    row3_buf_idx,
    output logic [conv_pkg::dim_w-1:0]     row1_buf_adr,
    output logic [conv_pkg::dim_w-1:0]     row2_buf_adr,
    output logic [conv_pkg::dim_w-1:0]     row3_buf_adr
);
    import conv_pkg::*;

    logic signed [dim_w-1:0] row_nxt  [line_bufs];
    logic signed [dim_w-1:0] row_q    [line_bufs];
    logic [slot_w-1:0]       slot_nxt [line_bufs];
    logic [slot_w-1:0]       slot_q   [line_bufs];
    logic [line_bufs-1:0]    mask_nxt;
    logic [dim_w-1:0]        adr_q;

    // Only a window on the outputs can be consumed
    assign consume = route_valid && shift_add_end;

    always_comb begin
        logic [slot_w:0] sum;
        for (int j = 0; j < line_bufs; j++) begin
            row_nxt[j]  = win.top_row + $signed(dim_w'(j));
            // Inside the kernel and inside the image
            mask_nxt[j] = (krn_w'(j) < cfg.k) && !row_nxt[j][dim_w-1] &&
                          ($unsigned(row_nxt[j]) < cfg.iy);
            sum         = {1'b0, win.top_slot} + (slot_w+1)'(j);
            slot_nxt[j] = (sum >= 3'd3) ? slot_w'(sum - 3'd3) : slot_w'(sum);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            route_valid <= 1'b0;
        end else if (consume) begin
            route_valid <= 1'b0;
        end else if (win.win_valid) begin
            route_valid <= 1'b1;
        end
    end

    // Window registers, held while route_valid waits
    always_ff @(posedge clk) begin
        if (win.win_valid && !route_valid) begin
            row_q    <= row_nxt;
            slot_q   <= slot_nxt;
            row_mask <= mask_nxt;
            if_idx   <= win.if_idx;
            adr_q    <= win.if_idx << cfg.ix_in_2pow;
        end
    end

    assign row1_idx     = row_q[0];
    assign row2_idx     = row_q[1];
    assign row3_idx     = row_q[2];
    assign row1_buf_idx = slot_q[0];
    assign row2_buf_idx = slot_q[1];
    assign row3_buf_idx = slot_q[2];
    assign row1_buf_adr = adr_q;
    assign row2_buf_adr = adr_q;
    assign row3_buf_adr = adr_q;

endmodule

`default_nettype wire

/* src/conv_row_sequencer.sv */
`timescale 1ns/100ps
`default_nettype none

module conv_row_sequencer (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         en,
    input  logic [conv_pkg::dim_w-1:0]   ix,
    input  logic [conv_pkg::dim_w-1:0]   iy,
    input  logic [conv_pkg::dim_w-1:0]   ox,
    input  logic [conv_pkg::dim_w-1:0]   oy,
    input  logic [conv_pkg::dim_w-1:0]   nif,
    input  logic [conv_pkg::krn_w-1:0]   k,
    input  logic [conv_pkg::krn_w-1:0]   s,
    input  logic [conv_pkg::krn_w-1:0]   p,
    input  logic [conv_pkg::log_w-1:0]   ix_in_2pow,
    input  logic [conv_pkg::log_w-1:0]   nif_in_2pow,
    input  logic                         consume,
    conv_cfg_if.owner                    cfg,
    conv_window_if.issuer                win,
    output logic                         busy,
    output logic                         conv_end
);
    import conv_pkg::*;

    seq_state_t        state;
    logic [dim_w-1:0]  oy_last;
    logic [slot_w-1:0] step_slot;
    logic [slot_w-1:0] start_slot;
    logic [slot_w-1:0] next_slot;
    logic [slot_w:0]   slot_sum;
    logic              last_ch;
    logic              last_row;
    logic              take_en;

    // Remainder of a small value by 3, by repeated subtraction
    function automatic logic [slot_w-1:0] mod3(input logic [krn_w-1:0] v);
        logic [krn_w-1:0] r;
        r = v;
        for (int i = 0; i < 5; i++) begin
            if (r >= krn_w'(3)) begin
                r = r - krn_w'(3);
            end
        end
        return r[slot_w-1:0];
    endfunction

    ////////////////////////////////////////
    // State machine
    ////////////////////////////////////////

    assign take_en  = en && (state == seq_idle || state == seq_end);
    assign last_ch  = (win.if_idx == cfg.nif - dim_w'(1));
    assign last_row = (win.oy_idx == oy_last - dim_w'(1));

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= seq_idle;
        end else begin
            case (state)
                seq_idle, seq_end: state <= take_en ? seq_latch : seq_idle;
                seq_latch:         state <= seq_issue;
                seq_issue:         state <= seq_wait;
                seq_wait: begin
                    if (consume) begin
                        state <= (last_ch && last_row) ? seq_end : seq_issue;
                    end
                end
                default:           state <= seq_idle;
            endcase
        end
    end

    assign win.win_valid = (state == seq_issue);
    assign busy          = (state == seq_latch) || (state == seq_issue) || (state == seq_wait);
    assign conv_end      = (state == seq_end);

    ////////////////////////////////////////
    // Configuration and window counters
    ////////////////////////////////////////

    // (-p) mod 3, taken non-negative
    assign start_slot = (mod3(cfg.p) == '0) ? '0 : slot_w'(3) - mod3(cfg.p);

    // Slot of the next output row, wrapped without division
    assign slot_sum  = {1'b0, win.top_slot} + {1'b0, step_slot};
    assign next_slot = (slot_sum >= 3'd3) ? slot_w'(slot_sum - 3'd3) : slot_w'(slot_sum);

    always_ff @(posedge clk) begin
        if (take_en) begin
            cfg.ix          <= ix;
            cfg.iy          <= iy;
            cfg.nif         <= nif;
            cfg.k           <= k;
            cfg.s           <= s;
            cfg.p           <= p;
            cfg.ix_in_2pow  <= ix_in_2pow;
            cfg.nif_in_2pow <= nif_in_2pow;
            oy_last         <= oy;
        end

        if (state == seq_latch) begin
            win.top_row  <= -$signed({{(dim_w-krn_w){1'b0}}, cfg.p});
            win.top_slot <= start_slot;
            win.if_idx   <= '0;
            win.oy_idx   <= '0;
            step_slot    <= mod3(cfg.s);
        end else if (state == seq_wait && consume && !(last_ch && last_row)) begin
            if (last_ch) begin
                // Next output row, channels start over
                win.if_idx   <= '0;
                win.oy_idx   <= win.oy_idx + dim_w'(1);
                win.top_row  <= win.top_row + $signed({{(dim_w-krn_w){1'b0}}, cfg.s});
                win.top_slot <= next_slot;
            end else begin
                win.if_idx <= win.if_idx + dim_w'(1);
            end
        end
    end

endmodule

`default_nettype wire

/* src/conv_window_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface conv_window_if;
    import conv_pkg::*;

    logic                    win_valid;
    logic signed [dim_w-1:0] top_row;   // negative inside the top padding
    logic [slot_w-1:0]       top_slot;
    logic [dim_w-1:0]        if_idx;
    logic [dim_w-1:0]        oy_idx;

    modport issuer (
        output win_valid, top_row, top_slot, if_idx, oy_idx
    );

    modport mapper (
        input win_valid, top_row, top_slot, if_idx, oy_idx
    );

endinterface

`default_nettype wire

/* src/conv_cfg_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface conv_cfg_if;
    import conv_pkg::*;

    // Layer configuration, held from the latch until conv_end
    logic [dim_w-1:0] ix;
    logic [dim_w-1:0] iy;
    logic [dim_w-1:0] nif;
    logic [krn_w-1:0] k;
    logic [krn_w-1:0] s;
    logic [krn_w-1:0] p;
    logic [log_w-1:0] ix_in_2pow;
    logic [log_w-1:0] nif_in_2pow;

    modport owner (
        output ix, iy, nif, k, s, p, ix_in_2pow, nif_in_2pow
    );

    modport user (
        input ix, iy, nif, k, s, p, ix_in_2pow, nif_in_2pow
    );

endinterface

`default_nettype wire

/* src/conv_pkg.sv */
`default_nettype none

package conv_pkg;

    // Sizes, row indices, counts and addresses
    localparam int dim_w = 16;

    // Kernel height, stride and padding
    localparam int krn_w = 4;

    // Base-2 logarithms of ix and nif
    localparam int log_w = 4;

    // Rotating line buffers, one per kernel row
    localparam int line_bufs = 3;
    localparam int slot_w    = 2;

    typedef enum logic [2:0] {
        seq_idle,
        seq_latch,
        seq_issue,
        seq_wait,
        seq_end
    } seq_state_t;

endpackage

`default_nettype wire
